//--- common/axi4_stub_pkg.sv
// Fixed 32-bit address and data, 4-bit IDs; cache, prot, lock, region, qos, size, burst and user are not carried
`default_nettype none

package axi4_stub_pkg;

   //////////////////////////////
   // Bus widths
   //////////////////////////////

   // Byte address
   localparam int unsigned axi_addr_w = 32;
   localparam int unsigned axi_data_w = 32;

   // Transaction ID, echoed back on B and R
   localparam int unsigned axi_id_w   = 4;

   // Full AXI4 length field, up to 256 beats
   localparam int unsigned axi_len_w  = 8;

   // One strobe bit per data byte
   localparam int unsigned axi_strb_w = axi_data_w / 8;

   //////////////////////////////
   // Response codes
   //////////////////////////////

   typedef logic [1:0] axi_resp_t;

   // Only code the stub ever returns
   localparam axi_resp_t resp_okay = 2'b00;

   //////////////////////////////
   // Channel beats
   //////////////////////////////

   // Write address, 44 bits
   typedef struct packed {
      logic [axi_addr_w-1:0] awaddr;
      logic [axi_id_w-1:0]   awid;
      logic [axi_len_w-1:0]  awlen;
   } aw_beat_t;

   // Write data, 37 bits
   typedef struct packed {
      logic [axi_data_w-1:0] wdata;
      logic [axi_strb_w-1:0] wstrb;
      logic                  wlast;
   } w_beat_t;

   // Read address, same layout as AW
   typedef struct packed {
      logic [axi_addr_w-1:0] araddr;
      logic [axi_id_w-1:0]   arid;
      logic [axi_len_w-1:0]  arlen;
   } ar_beat_t;

   // Write response, 6 bits
   typedef struct packed {
      logic [axi_id_w-1:0] bid;
      axi_resp_t           bresp;
   } b_beat_t;

   // Read data, 39 bits
   typedef struct packed {
      logic [axi_id_w-1:0]   rid;
      logic [axi_data_w-1:0] rdata;
      axi_resp_t             rresp;
      logic                  rlast;
   } r_beat_t;

endpackage

`default_nettype wire

//--- hw/axi4_chan_buf.sv
// Two entries, one cycle from input to output; payload has no reset, so out_data is X until the first beat
`timescale 1ns/100ps
`default_nettype none

module axi4_chan_buf #(
   parameter type payload_t = logic
) (
   input  logic     aclk,
   input  logic     reset,
   // Upstream side
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   // Downstream side
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   //////////////////////////////
   // Storage
   //////////////////////////////

   // Head entry, drives the outputs
   logic     head_valid;
   payload_t head_data;

   // Skid entry, only filled while the head is stalled
   logic     skid_valid;
   payload_t skid_data;

   logic head_free;
   logic in_fire;

   // Head can take a new beat when empty or being taken
   assign head_free = !head_valid || out_ready;
   assign in_fire   = in_valid && in_ready;

   // Ready comes from a flop, no path back to out_ready
   assign in_ready  = !skid_valid;

   assign out_valid = head_valid;
   assign out_data  = head_data;

   //////////////////////////////
   // Control
   //////////////////////////////

   always_ff @(posedge aclk)
   begin
      if (reset)
      begin
         head_valid <= 1'b0;
         skid_valid <= 1'b0;
      end
      else if (head_free)
      begin
         // Skid beat is older, and blocks the input while held
         head_valid <= skid_valid || in_valid;
         skid_valid <= 1'b0;
      end
      else if (in_fire)
      begin
         // Head stalled, park the beat
         skid_valid <= 1'b1;
      end
   end

   // Payload follows the same decisions
   always_ff @(posedge aclk)
   begin
      if (head_free)
      begin
         if (skid_valid)
            head_data <= skid_data;
         else if (in_valid)
            head_data <= in_data;
      end
      else if (in_fire)
      begin
         skid_data <= in_data;
      end
   end

endmodule

`default_nettype wire

//--- hw/axi4_write_resp.sv
// Responses are always OKAY and in AW order; W data and strobes are accepted and discarded
`timescale 1ns/100ps
`default_nettype none

module axi4_write_resp (
   input  logic                    aclk,
   input  logic                    reset,
   // Write address in
   input  logic                    aw_valid,
   output logic                    aw_ready,
   input  axi4_stub_pkg::aw_beat_t aw,
   // Write data in
   input  logic                    w_valid,
   output logic                    w_ready,
   input  axi4_stub_pkg::w_beat_t  w,
   // Write response out
   output logic                    b_valid,
   input  logic                    b_ready,
   output axi4_stub_pkg::b_beat_t  b
);

   import axi4_stub_pkg::*;

   //////////////////////////////
   // Response slot
   //////////////////////////////

   // One registered B beat
   logic                b_full;
   logic [axi_id_w-1:0] bid_q;

   // Slot empty, or emptied this cycle
   logic slot_free;

   // Last W beat meets the head AW beat
   logic burst_done;

   assign slot_free  = !b_full || b_ready;
   assign burst_done = aw_valid && w_valid && w.wlast && slot_free;

   //////////////////////////////
   // Input handshakes
   //////////////////////////////

   // AW waits for the burst's closing beat
   assign aw_ready = w_valid && w.wlast && slot_free;

   // Middle beats drain freely; the wlast beat waits for its AW
   // Both stall while B is blocked
   assign w_ready  = slot_free && (!w.wlast || aw_valid);

   // Load the slot on a completed burst
   always_ff @(posedge aclk)
   begin
      if (reset)
      begin
         b_full <= 1'b0;
      end
      else if (burst_done)
      begin
         b_full <= 1'b1;
      end
      else if (b_ready)
      begin
         b_full <= 1'b0;
      end
   end

   // ID of the oldest AW beat
   always_ff @(posedge aclk)
   begin
      if (burst_done)
      begin
         bid_q <= aw.awid;
      end
   end

   //////////////////////////////
   // Output
   //////////////////////////////

   assign b_valid = b_full;

   // Response code is a constant
   assign b = '{bid: bid_q, bresp: resp_okay};

endmodule

`default_nettype wire

//--- hw/axi4_read_resp.sv
// Returns arlen+1 beats of read_fill per AR beat, always OKAY; address is ignored, one burst at a time
`timescale 1ns/100ps
`default_nettype none

module axi4_read_resp #(
   parameter logic [axi4_stub_pkg::axi_data_w-1:0] read_fill = '1
) (
   input  logic                    aclk,
   input  logic                    reset,
   // Read address in
   input  logic                    ar_valid,
   output logic                    ar_ready,
   input  axi4_stub_pkg::ar_beat_t ar,
   // Read data out
   output logic                    r_valid,
   input  logic                    r_ready,
   output axi4_stub_pkg::r_beat_t  r
);

   import axi4_stub_pkg::*;

   //////////////////////////////
   // Burst state
   //////////////////////////////

   // High for the whole burst
   logic                 busy;

   // Beats left after the current one
   logic [axi_len_w-1:0] beat_cnt;
   logic [axi_id_w-1:0]  rid_q;

   logic last_beat;
   logic last_fire;
   logic ar_fire;

   assign last_beat = (beat_cnt == '0);
   assign last_fire = busy && r_ready && last_beat;

   // Next burst may start right behind the last beat
   assign ar_ready  = !busy || last_fire;
   assign ar_fire   = ar_valid && ar_ready;

   always_ff @(posedge aclk)
   begin
      if (reset)
      begin
         busy <= 1'b0;
      end
      else if (ar_fire)
      begin
         busy <= 1'b1;
      end
      else if (last_fire)
      begin
         busy <= 1'b0;
      end
   end

   // Load from arlen, count down on each beat
   always_ff @(posedge aclk)
   begin
      if (ar_fire)
      begin
         beat_cnt <= ar.arlen;
         rid_q    <= ar.arid;
      end
      else if (busy && r_ready && !last_beat)
      begin
         beat_cnt <= beat_cnt - 1'b1;
      end
   end

   //////////////////////////////
   // Output
   //////////////////////////////

   assign r_valid = busy;

   // Fixed data and code, ID echoed
   assign r = '{rid: rid_q, rdata: read_fill, rresp: resp_okay, rlast: last_beat};

endmodule

`default_nettype wire

//--- hw/axi4_stub_slave.sv
// Stores nothing; every write gets OKAY, every read returns read_fill; each path adds three flop stages
`timescale 1ns/100ps
`default_nettype none

module axi4_stub_slave #(
   parameter logic [axi4_stub_pkg::axi_data_w-1:0] read_fill = '1
) (
   input  logic                    aclk,
   input  logic                    reset,
   // Write address
   input  logic                    awvalid,
   output logic                    awready,
   input  axi4_stub_pkg::aw_beat_t aw,
   // Write data
   input  logic                    wvalid,
   output logic                    wready,
   input  axi4_stub_pkg::w_beat_t  w,
   // Read address
   input  logic                    arvalid,
   output logic                    arready,
   input  axi4_stub_pkg::ar_beat_t ar,
   // Write response
   output logic                    bvalid,
   input  logic                    bready,
   output axi4_stub_pkg::b_beat_t  b,
   // Read data
   output logic                    rvalid,
   input  logic                    rready,
   output axi4_stub_pkg::r_beat_t  r
);

   import axi4_stub_pkg::*;

   // Buffered request channels
   logic     aw_int_valid, aw_int_ready;
   aw_beat_t aw_int;
   logic     w_int_valid, w_int_ready;
   w_beat_t  w_int;
   logic     ar_int_valid, ar_int_ready;
   ar_beat_t ar_int;

   // Responder outputs, before their buffers
   logic     b_int_valid, b_int_ready;
   b_beat_t  b_int;
   logic     r_int_valid, r_int_ready;
   r_beat_t  r_int;

   //////////////////////////////
   // Request side
   //////////////////////////////

   axi4_chan_buf #(.payload_t(aw_beat_t)) aw_buf (
      .aclk(aclk), .reset(reset),
      .in_valid(awvalid), .in_ready(awready), .in_data(aw),
      .out_valid(aw_int_valid), .out_ready(aw_int_ready), .out_data(aw_int)
   );

   axi4_chan_buf #(.payload_t(w_beat_t)) w_buf (
      .aclk(aclk), .reset(reset),
      .in_valid(wvalid), .in_ready(wready), .in_data(w),
      .out_valid(w_int_valid), .out_ready(w_int_ready), .out_data(w_int)
   );

   axi4_chan_buf #(.payload_t(ar_beat_t)) ar_buf (
      .aclk(aclk), .reset(reset),
      .in_valid(arvalid), .in_ready(arready), .in_data(ar),
      .out_valid(ar_int_valid), .out_ready(ar_int_ready), .out_data(ar_int)
   );

   //////////////////////////////
   // Responders
   //////////////////////////////

   axi4_write_resp write_resp_i (
      .aclk(aclk), .reset(reset),
      .aw_valid(aw_int_valid), .aw_ready(aw_int_ready), .aw(aw_int),
      .w_valid(w_int_valid), .w_ready(w_int_ready), .w(w_int),
      .b_valid(b_int_valid), .b_ready(b_int_ready), .b(b_int)
   );

   axi4_read_resp #(.read_fill(read_fill)) read_resp_i (
      .aclk(aclk), .reset(reset),
      .ar_valid(ar_int_valid), .ar_ready(ar_int_ready), .ar(ar_int),
      .r_valid(r_int_valid), .r_ready(r_int_ready), .r(r_int)
   );

   //////////////////////////////
   // Response side
   //////////////////////////////

   axi4_chan_buf #(.payload_t(b_beat_t)) b_buf (
      .aclk(aclk), .reset(reset),
      .in_valid(b_int_valid), .in_ready(b_int_ready), .in_data(b_int),
      .out_valid(bvalid), .out_ready(bready), .out_data(b)
   );

   axi4_chan_buf #(.payload_t(r_beat_t)) r_buf (
      .aclk(aclk), .reset(reset),
      .in_valid(r_int_valid), .in_ready(r_int_ready), .in_data(r_int),
      .out_valid(rvalid), .out_ready(rready), .out_data(r)
   );

endmodule

`default_nettype wire

//--- verif/axi4_stub_clkgen.sv
// Clock runs from time zero; reset is held high for reset_cycles rising edges, then released
`timescale 1ns/100ps
`default_nettype none

module axi4_stub_clkgen #(
   parameter int period_ns    = 100,
   parameter int reset_cycles = 3
) (
   output logic aclk,
   output logic reset
);

   // Free-running clock, low for the first half period
   initial
   begin
      aclk = 1'b0;
      forever #(period_ns / 2) aclk = ~aclk;
   end

   // Released on a rising edge, like every other stimulus
   initial
   begin
      reset <= 1'b1;
      repeat (reset_cycles) @(posedge aclk);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire

//--- verif/axi4_stub_checks.svh
// Included inside the testbench module body; needs fill_pattern, mismatch_cnt and the package import there
`ifndef AXI4_STUB_CHECKS_SVH
`define AXI4_STUB_CHECKS_SVH

   //////////////////////////////
   // Reference model
   //////////////////////////////

   // One OKAY per write burst, tagged with its awid
   function automatic b_beat_t expect_b(input aw_beat_t req);
      b_beat_t exp;
      exp.bid   = req.awid;
      exp.bresp = resp_okay;
      return exp;
   endfunction

   // Beats are numbered from zero, the last one is arlen
   function automatic r_beat_t expect_r(input ar_beat_t req, input logic [axi_len_w-1:0] beat);
      r_beat_t exp;
      exp.rid   = req.arid;
      exp.rdata = fill_pattern;
      exp.rresp = resp_okay;
      exp.rlast = (beat == req.arlen);
      return exp;
   endfunction

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic check_b(input string name, input b_beat_t exp, input b_beat_t act);
      if (act !== exp)
      begin
         $display("MISMATCH %s: B expected bid=%h bresp=%h, actual bid=%h bresp=%h",
                  name, exp.bid, exp.bresp, act.bid, act.bresp);
         mismatch_cnt++;
      end
   endtask

   task automatic check_r(input string name, input r_beat_t exp, input r_beat_t act);
      if (act !== exp)
      begin
         $display("MISMATCH %s: R expected %h/%h/%h/%b, actual %h/%h/%h/%b (rid/rdata/rresp/rlast)",
                  name, exp.rid, exp.rdata, exp.rresp, exp.rlast,
                  act.rid, act.rdata, act.rresp, act.rlast);
         mismatch_cnt++;
      end
   endtask

   // Single handshake or status bit
   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
         mismatch_cnt++;
      end
   endtask

`endif

//--- verif/axi4_stub_tb.sv
// Fixed seed, so every run replays the same traffic; needs a simulator with timing control support
`timescale 1ns/100ps
`default_nettype none

module axi4_stub_tb;

   import axi4_stub_pkg::*;

   // Distinct from the all-ones default
   localparam logic [axi_data_w-1:0] fill_pattern = 32'hC0DE_5A17;

   // Four directed transactions plus 50 random ones
   localparam int n_txn       = 54;
   localparam int cycle_limit = 40 * n_txn + 200;

   logic     aclk;
   logic     reset;

   // Master side idles from time zero
   logic     awvalid = 1'b0;
   aw_beat_t aw      = '0;
   logic     wvalid  = 1'b0;
   w_beat_t  w       = '0;
   logic     arvalid = 1'b0;
   ar_beat_t ar      = '0;
   logic     bready  = 1'b0;
   logic     rready  = 1'b0;

   logic     awready, wready, arready, bvalid, rvalid;
   b_beat_t  b;
   r_beat_t  r;

   // Beats waiting to be driven on each channel
   aw_beat_t aw_cmd_q[$];
   w_beat_t  w_cmd_q[$];
   ar_beat_t ar_cmd_q[$];

   // Requests still owed a response in issue order
   aw_beat_t wr_exp_q[$];
   ar_beat_t rd_exp_q[$];

   integer   seed          = 88977;
   logic     traffic_gaps  = 1'b0;
   logic     random_ready  = 1'b0;
   string    test_name     = "reset";
   int       mismatch_cnt  = 0;
   int       other_err_cnt = 0;
   int       cycle_cnt     = 0;
   int       wlast_cnt     = 0;
   int       b_cnt         = 0;
   logic [axi_len_w-1:0] r_beat_idx = '0;

   `include "axi4_stub_checks.svh"

   axi4_stub_clkgen #(.period_ns(100), .reset_cycles(3)) clkgen_i (.aclk(aclk), .reset(reset));

   axi4_stub_slave #(.read_fill(fill_pattern)) dut_i (
      .aclk(aclk), .reset(reset),
      .awvalid(awvalid), .awready(awready), .aw(aw),
      .wvalid(wvalid), .wready(wready), .w(w),
      .arvalid(arvalid), .arready(arready), .ar(ar),
      .bvalid(bvalid), .bready(bready), .b(b),
      .rvalid(rvalid), .rready(rready), .r(r)
   );

   // Roughly one idle cycle in four while gaps are on
   function automatic logic go_now();
      return !traffic_gaps || (($random(seed) & 3) != 0);
   endfunction

   task automatic report_counts();
      $display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_err_cnt);
   endtask

   //////////////////////////////
   // Drivers
   //////////////////////////////

   // A beat stays on the bus until its ready is seen
   always @(posedge aclk)
   begin
      if ((!awvalid || awready) && aw_cmd_q.size() > 0 && go_now())
      begin
         aw      <= aw_cmd_q.pop_front();
         awvalid <= 1'b1;
      end
      else if (awready)
         awvalid <= 1'b0;
      if ((!wvalid || wready) && w_cmd_q.size() > 0 && go_now())
      begin
         w      <= w_cmd_q.pop_front();
         wvalid <= 1'b1;
      end
      else if (wready)
         wvalid <= 1'b0;
      if ((!arvalid || arready) && ar_cmd_q.size() > 0 && go_now())
      begin
         ar      <= ar_cmd_q.pop_front();
         arvalid <= 1'b1;
      end
      else if (arready)
         arvalid <= 1'b0;
      // Back-pressure on the response channels
      bready <= !random_ready || (($random(seed) & 1) != 0);
      rready <= !random_ready || (($random(seed) & 1) != 0);
   end

   //////////////////////////////
   // Monitor and watchdog
   //////////////////////////////

   // Values seen here are the ones from before the edge
   always @(posedge aclk)
   begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit)
      begin
         $display("ERROR: run hung after %0d cycles, %0d writes and %0d reads unanswered",
                  cycle_limit, wr_exp_q.size(), rd_exp_q.size());
         other_err_cnt++;
         report_counts();
         $display("*** FAILED ***");
         $finish;
      end
      else
      begin
         if (bvalid && bready)
         begin
            if (wr_exp_q.size() == 0)
            begin
               $display("ERROR: %s: B response with no write outstanding", test_name);
               other_err_cnt++;
            end
            else
               check_b(test_name, expect_b(wr_exp_q.pop_front()), b);
            // Counted before this edge's wlast, so a same-edge B is caught
            if (b_cnt >= wlast_cnt)
            begin
               $display("ERROR: %s: B response came before its wlast beat", test_name);
               other_err_cnt++;
            end
            b_cnt++;
         end
         if (wvalid && wready && w.wlast)
            wlast_cnt++;
         if (rvalid && rready)
         begin
            if (rd_exp_q.size() == 0)
            begin
               $display("ERROR: %s: R beat with no read outstanding", test_name);
               other_err_cnt++;
            end
            else
            begin
               check_r(test_name, expect_r(rd_exp_q[0], r_beat_idx), r);
               if (r_beat_idx == rd_exp_q[0].arlen)
               begin
                  void'(rd_exp_q.pop_front());
                  r_beat_idx = '0;
               end
               else
                  r_beat_idx = r_beat_idx + 1'b1;
            end
         end
      end
   end

   //////////////////////////////
   // Request helpers
   //////////////////////////////

   // w_first holds the AW beat back until all W beats are out
   task automatic issue_write(input logic [axi_id_w-1:0] id, input logic [axi_len_w-1:0] len,
                              input logic w_first);
      aw_beat_t a;
      w_beat_t  d;
      int       i;
      a.awaddr = $random(seed);
      a.awid   = id;
      a.awlen  = len;
      for (i = 0; i <= int'(len); i++)
      begin
         d.wdata = $random(seed);
         d.wstrb = '1;
         d.wlast = (i == int'(len));
         w_cmd_q.push_back(d);
      end
      if (w_first)
      begin
         while (w_cmd_q.size() > 0)
            @(negedge aclk);
         repeat (6) @(negedge aclk);
      end
      aw_cmd_q.push_back(a);
      wr_exp_q.push_back(a);
   endtask

   task automatic issue_read(input logic [axi_id_w-1:0] id, input logic [axi_len_w-1:0] len);
      ar_beat_t a;
      a.araddr = $random(seed);
      a.arid   = id;
      a.arlen  = len;
      ar_cmd_q.push_back(a);
      rd_exp_q.push_back(a);
   endtask

   // All answered and then quiet long enough for extra beats to show up
   task automatic wait_idle();
      while (aw_cmd_q.size() > 0 || w_cmd_q.size() > 0 || ar_cmd_q.size() > 0 ||
             wr_exp_q.size() > 0 || rd_exp_q.size() > 0)
         @(negedge aclk);
      repeat (10) @(negedge aclk);
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial
   begin
      int rnd;
      @(negedge reset);
      @(negedge aclk);
      check_flag("reset bvalid", 1'b0, bvalid);
      check_flag("reset rvalid", 1'b0, rvalid);
      check_flag("reset awready", 1'b1, awready);
      check_flag("reset wready", 1'b1, wready);
      check_flag("reset arready", 1'b1, arready);

      test_name = "single write";
      issue_write(4'h3, 8'd0, 1'b0);
      wait_idle();

      test_name = "burst write";
      issue_write(4'h5, 8'd3, 1'b0);
      wait_idle();
      test_name = "data before address";
      issue_write(4'h9, 8'd3, 1'b1);
      wait_idle();

      test_name = "read burst";
      issue_read(4'hA, 8'd7);
      wait_idle();

      // Mixed traffic with bursts of one to four beats
      test_name = "random mix";
      traffic_gaps = 1'b1;
      random_ready = 1'b1;
      repeat (50)
      begin
         rnd = $random(seed);
         if (rnd[0])
            issue_write(rnd[4:1], {6'd0, rnd[6:5]}, 1'b0);
         else
            issue_read(rnd[4:1], {6'd0, rnd[6:5]});
      end
      wait_idle();

      report_counts();
      if (mismatch_cnt == 0 && other_err_cnt == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verif
common/axi4_stub_pkg.sv
hw/axi4_chan_buf.sv
hw/axi4_write_resp.sv
hw/axi4_read_resp.sv
hw/axi4_stub_slave.sv
verif/axi4_stub_clkgen.sv
verif/axi4_stub_tb.sv

//--- Makefile
# Verilator build and run of the AXI4 stub slave testbench

VERILATOR ?= verilator
TOP       ?= axi4_stub_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard verif/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -qx '\*\*\* PASSED \*\*\*' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
